// ==== flist.f ====
+incdir+rtl
rtl/smem_pkg.sv
rtl/mem_req_pkg.sv
rtl/fwd_decide_stage.sv
rtl/fwd_update_stage.sv
rtl/fwd_request_stage.sv
rtl/fwd_extend_top.sv
verification/tb_fwd_extend.sv

// ==== rtl/fmi_defs.svh ====
`ifndef FMI_DEFS_SVH
`define FMI_DEFS_SVH

// ------------------------------
// index format
`define FMI_READ_LEN   101 // longest read the forward search handles
`define FMI_INTV_W     64  // one sa interval field
`define FMI_STEP_W     7   // step index and min_intv
`define FMI_READ_NUM_W 10
`define FMI_PTR_W      7   // curr queue holds 128 entries per read
`define FMI_ADDR_W     32

// ------------------------------
// cache line slice of a bound
`define FMI_LINE_HI    34
`define FMI_LINE_LO    7
`define FMI_LINE_PAD   4   // zero bits below the line index

`endif

// ==== rtl/fwd_decide_stage.sv ====
`default_nettype none

`include "fmi_defs.svh"

module fwd_decide_stage (
	input  wire                       Clk_32UI,
	input  wire                       reset_BWT_extend,
	input  wire                       stall_i,
	input  wire smem_pkg::status_e    status_i,
	input  wire smem_pkg::step_t      step_i,
	input  wire smem_pkg::step_t      min_intv_i,
	input  wire smem_pkg::step_t      backward_x_i,
	input  wire mem_req_pkg::ptr_t    ptr_i,
	input  wire smem_pkg::read_num_t  read_num_i,
	input  wire smem_pkg::intv_t      ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  wire smem_pkg::intv_t      occ_x0_i, occ_x1_i, occ_x2_i,
	output logic                      curr_we_o,
	output mem_req_pkg::ptr_t         curr_addr_o,
	output mem_req_pkg::curr_entry_t  curr_data_o,
	output smem_pkg::read_num_t       curr_read_num_o,
	output logic                      ret_valid_o,
	output smem_pkg::step_t           ret_o,
	output smem_pkg::read_num_t       ret_read_num_o,
	output smem_pkg::status_e         status_o,
	output smem_pkg::step_t           step_o,
	output smem_pkg::step_t           min_intv_o,
	output smem_pkg::step_t           backward_x_o,
	output mem_req_pkg::ptr_t         ptr_o,
	output smem_pkg::read_num_t       read_num_o,
	output smem_pkg::intv_t           ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output smem_pkg::intv_t           occ_x0_o, occ_x1_o, occ_x2_o,
	output logic                      do_update_o
);

	import smem_pkg::*;
	import mem_req_pkg::*;

	logic len_hit;      // no base left to extend with
	logic at_len;
	logic run_step;
	logic brk_step;
	logic intv_changed; // occ result shrank the interval
	logic intv_small;
	ptr_t ptr_inc;

	assign len_hit      = (step_i >= step_t'(`FMI_READ_LEN));
	assign at_len       = (step_i == step_t'(`FMI_READ_LEN));
	assign run_step     = (status_i == st_f_run) && !len_hit;
	assign brk_step     = (status_i == st_f_break) || ((status_i == st_f_run) && len_hit);
	assign intv_changed = (occ_x2_i != ik_x2_i);
	assign intv_small   = (occ_x2_i < intv_t'(min_intv_i));
	assign ptr_inc      = ptr_i + ptr_t'(1);

	// ------------------------------
	// step end decision
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o    <= st_bubble;
			curr_we_o   <= 1'b0;
			ret_valid_o <= 1'b0;
			do_update_o <= 1'b0;
		end else if (!stall_i) begin
			curr_we_o   <= 1'b0;
			ret_valid_o <= 1'b0;
			do_update_o <= 1'b0;
			status_o    <= status_i; // f_init, backward and bubble pass
			if (run_step) begin
				do_update_o <= !(intv_changed && intv_small);
				if (intv_changed) begin
					curr_we_o <= 1'b1; // save the old ik before it shrinks
					if (intv_small)
						status_o <= st_f_break;
				end
			end else if (brk_step) begin
				curr_we_o   <= at_len; // full length match is kept too
				ret_valid_o <= 1'b1;
				status_o    <= st_bck_ini;
			end
		end
	end

	// ------------------------------
	// item and curr queue payload
	always_ff @(posedge Clk_32UI) begin
		if (!stall_i) begin
			if ((run_step && intv_changed) || (brk_step && at_len))
				ptr_o <= ptr_inc;
			else
				ptr_o <= ptr_i;
			curr_addr_o     <= ptr_i;
			curr_data_o     <= {ik_info_i, ik_x2_i, ik_x1_i, ik_x0_i};
			curr_read_num_o <= read_num_i;
			ret_o           <= ik_info_i[`FMI_STEP_W-1:0]; // break position
			ret_read_num_o  <= read_num_i;
			step_o          <= step_i;
			min_intv_o      <= min_intv_i;
			backward_x_o    <= backward_x_i;
			read_num_o      <= read_num_i;
			ik_x0_o         <= ik_x0_i;
			ik_x1_o         <= ik_x1_i;
			ik_x2_o         <= ik_x2_i;
			ik_info_o       <= ik_info_i;
			occ_x0_o        <= occ_x0_i;
			occ_x1_o        <= occ_x1_i;
			occ_x2_o        <= occ_x2_i;
		end
	end

	// a break report always hands the item to the backward phase
	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		ret_valid_o |-> (status_o == st_bck_ini));

	assert property (@(posedge Clk_32UI) !reset_BWT_extend |=> !curr_we_o);

endmodule

`default_nettype wire

// ==== rtl/fwd_extend_top.sv ====
`default_nettype none

module fwd_extend_top (
	input  wire                       Clk_32UI,
	input  wire                       reset_BWT_extend,
	input  wire                       stall_i,
	input  wire smem_pkg::intv_t      primary_i,
	input  wire smem_pkg::status_e    status_i,
	input  wire smem_pkg::step_t      step_i,
	input  wire smem_pkg::step_t      min_intv_i,
	input  wire smem_pkg::step_t      backward_x_i,
	input  wire mem_req_pkg::ptr_t    ptr_i,
	input  wire smem_pkg::read_num_t  read_num_i,
	input  wire smem_pkg::intv_t      ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  wire smem_pkg::intv_t      occ_x0_i, occ_x1_i, occ_x2_i,
	output logic                      curr_we_o,
	output mem_req_pkg::ptr_t         curr_addr_o,
	output mem_req_pkg::curr_entry_t  curr_data_o,
	output smem_pkg::read_num_t       curr_read_num_o,
	output logic                      ret_valid_o,
	output smem_pkg::step_t           ret_o,
	output smem_pkg::read_num_t       ret_read_num_o,
	output smem_pkg::status_e         query_status_o,
	output smem_pkg::read_num_t       query_read_num_o,
	output smem_pkg::step_t           next_query_pos_o,
	output logic                      dram_valid_o,
	output mem_req_pkg::dram_addr_t   addr_k_o, addr_l_o,
	output smem_pkg::status_e         status_o,
	output smem_pkg::step_t           step_o,
	output smem_pkg::step_t           min_intv_o,
	output smem_pkg::step_t           backward_x_o,
	output mem_req_pkg::ptr_t         ptr_o,
	output smem_pkg::read_num_t       read_num_o,
	output smem_pkg::intv_t           ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o
);

	import smem_pkg::*;
	import mem_req_pkg::*;

	// ------------------------------
	// decide -> update
	status_e   d_status;
	step_t     d_step, d_min_intv, d_backward_x;
	ptr_t      d_ptr;
	read_num_t d_read_num;
	intv_t     d_ik_x0, d_ik_x1, d_ik_x2, d_ik_info;
	intv_t     d_occ_x0, d_occ_x1, d_occ_x2;
	logic      d_do_update;

	// ------------------------------
	// update -> request
	status_e   u_status;
	step_t     u_step, u_min_intv, u_backward_x;
	ptr_t      u_ptr;
	read_num_t u_read_num;
	intv_t     u_ik_x0, u_ik_x1, u_ik_x2, u_ik_info;
	intv_t     u_k_tmp, u_l_tmp, u_k_tmp_dec, u_l_tmp_dec;

	fwd_decide_stage fwd_decide_stage_inst (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(status_i), .step_i(step_i), .min_intv_i(min_intv_i),
		.backward_x_i(backward_x_i), .ptr_i(ptr_i), .read_num_i(read_num_i),
		.ik_x0_i(ik_x0_i), .ik_x1_i(ik_x1_i), .ik_x2_i(ik_x2_i), .ik_info_i(ik_info_i),
		.occ_x0_i(occ_x0_i), .occ_x1_i(occ_x1_i), .occ_x2_i(occ_x2_i),
		.curr_we_o(curr_we_o), .curr_addr_o(curr_addr_o), .curr_data_o(curr_data_o),
		.curr_read_num_o(curr_read_num_o),
		.ret_valid_o(ret_valid_o), .ret_o(ret_o), .ret_read_num_o(ret_read_num_o),
		.status_o(d_status), .step_o(d_step), .min_intv_o(d_min_intv),
		.backward_x_o(d_backward_x), .ptr_o(d_ptr), .read_num_o(d_read_num),
		.ik_x0_o(d_ik_x0), .ik_x1_o(d_ik_x1), .ik_x2_o(d_ik_x2), .ik_info_o(d_ik_info),
		.occ_x0_o(d_occ_x0), .occ_x1_o(d_occ_x1), .occ_x2_o(d_occ_x2),
		.do_update_o(d_do_update)
	);

	fwd_update_stage fwd_update_stage_inst (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(d_status), .step_i(d_step), .min_intv_i(d_min_intv),
		.backward_x_i(d_backward_x), .ptr_i(d_ptr), .read_num_i(d_read_num),
		.ik_x0_i(d_ik_x0), .ik_x1_i(d_ik_x1), .ik_x2_i(d_ik_x2), .ik_info_i(d_ik_info),
		.occ_x0_i(d_occ_x0), .occ_x1_i(d_occ_x1), .occ_x2_i(d_occ_x2),
		.do_update_i(d_do_update),
		.status_o(u_status), .step_o(u_step), .min_intv_o(u_min_intv),
		.backward_x_o(u_backward_x), .ptr_o(u_ptr), .read_num_o(u_read_num),
		.ik_x0_o(u_ik_x0), .ik_x1_o(u_ik_x1), .ik_x2_o(u_ik_x2), .ik_info_o(u_ik_info),
		.k_tmp_o(u_k_tmp), .l_tmp_o(u_l_tmp),
		.k_tmp_dec_o(u_k_tmp_dec), .l_tmp_dec_o(u_l_tmp_dec)
	);

	fwd_request_stage fwd_request_stage_inst (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i),
		.status_i(u_status), .step_i(u_step), .min_intv_i(u_min_intv),
		.backward_x_i(u_backward_x), .ptr_i(u_ptr), .read_num_i(u_read_num),
		.ik_x0_i(u_ik_x0), .ik_x1_i(u_ik_x1), .ik_x2_i(u_ik_x2), .ik_info_i(u_ik_info),
		.k_tmp_i(u_k_tmp), .l_tmp_i(u_l_tmp),
		.k_tmp_dec_i(u_k_tmp_dec), .l_tmp_dec_i(u_l_tmp_dec),
		.query_status_o(query_status_o), .query_read_num_o(query_read_num_o),
		.next_query_pos_o(next_query_pos_o),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o),
		.status_o(status_o), .step_o(step_o), .min_intv_o(min_intv_o),
		.backward_x_o(backward_x_o), .ptr_o(ptr_o), .read_num_o(read_num_o),
		.ik_x0_o(ik_x0_o), .ik_x1_o(ik_x1_o), .ik_x2_o(ik_x2_o), .ik_info_o(ik_info_o)
	);

endmodule

`default_nettype wire

// ==== rtl/fwd_request_stage.sv ====
`default_nettype none

`include "fmi_defs.svh"

module fwd_request_stage (
	input  wire                       Clk_32UI,
	input  wire                       reset_BWT_extend,
	input  wire                       stall_i,
	input  wire smem_pkg::intv_t      primary_i,
	input  wire smem_pkg::status_e    status_i,
	input  wire smem_pkg::step_t      step_i,
	input  wire smem_pkg::step_t      min_intv_i,
	input  wire smem_pkg::step_t      backward_x_i,
	input  wire mem_req_pkg::ptr_t    ptr_i,
	input  wire smem_pkg::read_num_t  read_num_i,
	input  wire smem_pkg::intv_t      ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  wire smem_pkg::intv_t      k_tmp_i, l_tmp_i, k_tmp_dec_i, l_tmp_dec_i,
	output smem_pkg::status_e         query_status_o,
	output smem_pkg::read_num_t       query_read_num_o,
	output smem_pkg::step_t           next_query_pos_o,
	output logic                      dram_valid_o,
	output mem_req_pkg::dram_addr_t   addr_k_o, addr_l_o,
	output smem_pkg::status_e         status_o,
	output smem_pkg::step_t           step_o,
	output smem_pkg::step_t           min_intv_o,
	output smem_pkg::step_t           backward_x_o,
	output mem_req_pkg::ptr_t         ptr_o,
	output smem_pkg::read_num_t       read_num_o,
	output smem_pkg::intv_t           ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o
);

	import smem_pkg::*;
	import mem_req_pkg::*;

	status_e   status_q;
	step_t     step_q, min_intv_q, backward_x_q;
	ptr_t      ptr_q;
	read_num_t read_num_q;
	intv_t     ik_x0_q, ik_x1_q, ik_x2_q, ik_info_q;
	intv_t     k_tmp_q, l_tmp_q, k_dec_q, l_dec_q;
	intv_t     k_bound, l_bound;
	logic      fetch;

	function automatic dram_addr_t line_addr(input intv_t bound);
		return {bound[`FMI_LINE_HI:`FMI_LINE_LO], {`FMI_LINE_PAD{1'b0}}};
	endfunction

	// the primary row is missing from the bwt, rows past it shift down by one
	assign k_bound = (k_tmp_q >= primary_i) ? k_dec_q : k_tmp_q;
	assign l_bound = (l_tmp_q >= primary_i) ? l_dec_q : l_tmp_q;
	assign fetch   = (status_q == st_f_init) || (status_q == st_f_run);

	// ------------------------------
	// control, both cycles
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_q       <= st_bubble;
			query_status_o <= st_bubble;
			status_o       <= st_bubble;
			dram_valid_o   <= 1'b0;
		end else if (!stall_i) begin
			status_q       <= status_i;
			query_status_o <= status_i; // query base fetched one cycle ahead
			status_o       <= (status_q == st_f_init) ? st_f_run : status_q;
			dram_valid_o   <= fetch; // no fetch after a break
		end
	end

	// ------------------------------
	// payload, both cycles
	always_ff @(posedge Clk_32UI) begin
		if (!stall_i) begin
			step_q           <= step_i;
			min_intv_q       <= min_intv_i;
			backward_x_q     <= backward_x_i;
			ptr_q            <= ptr_i;
			read_num_q       <= read_num_i;
			ik_x0_q          <= ik_x0_i;
			ik_x1_q          <= ik_x1_i;
			ik_x2_q          <= ik_x2_i;
			ik_info_q        <= ik_info_i;
			k_tmp_q          <= k_tmp_i;
			l_tmp_q          <= l_tmp_i;
			k_dec_q          <= k_tmp_dec_i;
			l_dec_q          <= l_tmp_dec_i;
			query_read_num_o <= read_num_i;
			next_query_pos_o <= step_i;
			addr_k_o         <= fetch ? line_addr(k_bound) : '0;
			addr_l_o         <= fetch ? line_addr(l_bound) : '0;
			step_o           <= step_q;
			min_intv_o       <= min_intv_q;
			backward_x_o     <= backward_x_q;
			ptr_o            <= ptr_q;
			read_num_o       <= read_num_q;
			ik_x0_o          <= ik_x0_q;
			ik_x1_o          <= ik_x1_q;
			ik_x2_o          <= ik_x2_q;
			ik_info_o        <= ik_info_q;
		end
	end

	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		dram_valid_o |-> (addr_k_o[`FMI_LINE_PAD-1:0] == '0)
			&& (addr_l_o[`FMI_LINE_PAD-1:0] == '0));

endmodule

`default_nettype wire

// ==== rtl/fwd_update_stage.sv ====
`default_nettype none

module fwd_update_stage (
	input  wire                       Clk_32UI,
	input  wire                       reset_BWT_extend,
	input  wire                       stall_i,
	input  wire smem_pkg::status_e    status_i,
	input  wire smem_pkg::step_t      step_i,
	input  wire smem_pkg::step_t      min_intv_i,
	input  wire smem_pkg::step_t      backward_x_i,
	input  wire mem_req_pkg::ptr_t    ptr_i,
	input  wire smem_pkg::read_num_t  read_num_i,
	input  wire smem_pkg::intv_t      ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  wire smem_pkg::intv_t      occ_x0_i, occ_x1_i, occ_x2_i,
	input  wire                       do_update_i,
	output smem_pkg::status_e         status_o,
	output smem_pkg::step_t           step_o,
	output smem_pkg::step_t           min_intv_o,
	output smem_pkg::step_t           backward_x_o,
	output mem_req_pkg::ptr_t         ptr_o,
	output smem_pkg::read_num_t       read_num_o,
	output smem_pkg::intv_t           ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output smem_pkg::intv_t           k_tmp_o, l_tmp_o, k_tmp_dec_o, l_tmp_dec_o
);

	import smem_pkg::*;

	logic  upd;
	intv_t nxt_x0, nxt_x1, nxt_x2, nxt_info;
	intv_t k_nxt, l_nxt;
	step_t nxt_step;

	assign upd      = (status_i == st_f_run) && do_update_i;
	assign nxt_x0   = upd ? occ_x0_i : ik_x0_i;
	assign nxt_x1   = upd ? occ_x1_i : ik_x1_i;
	assign nxt_x2   = upd ? occ_x2_i : ik_x2_i;
	assign nxt_step = upd ? step_i + step_t'(1) : step_i;
	assign nxt_info = upd ? intv_t'(nxt_step) : ik_info_i; // info records i+1

	// bounds of the interval that goes to memory
	assign k_nxt = nxt_x1 - intv_t'(1);
	assign l_nxt = k_nxt + nxt_x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend)
			status_o <= st_bubble;
		else if (!stall_i)
			status_o <= status_i;
	end

	// ------------------------------
	// commit ik and step, prepare both candidates of each bound
	always_ff @(posedge Clk_32UI) begin
		if (!stall_i) begin
			ik_x0_o      <= nxt_x0;
			ik_x1_o      <= nxt_x1;
			ik_x2_o      <= nxt_x2;
			ik_info_o    <= nxt_info;
			step_o       <= nxt_step;
			k_tmp_o      <= k_nxt;
			l_tmp_o      <= l_nxt;
			k_tmp_dec_o  <= k_nxt - intv_t'(1); // used when past the primary row
			l_tmp_dec_o  <= l_nxt - intv_t'(1);
			min_intv_o   <= min_intv_i;
			backward_x_o <= backward_x_i;
			ptr_o        <= ptr_i;
			read_num_o   <= read_num_i;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mem_req_pkg.sv ====
`default_nettype none

`include "fmi_defs.svh"

package mem_req_pkg;

	typedef logic [`FMI_PTR_W-1:0]    ptr_t;        // next free curr queue slot
	typedef logic [4*`FMI_INTV_W-1:0] curr_entry_t; // {info, x2, x1, x0}
	typedef logic [`FMI_ADDR_W-1:0]   dram_addr_t;  // cache line address

endpackage

`default_nettype wire

// ==== rtl/smem_pkg.sv ====
`default_nettype none

`include "fmi_defs.svh"

package smem_pkg;

	// one-hot search status, all zero marks an empty pipeline slot
	typedef enum logic [5:0] {
		st_bubble  = 6'b00_0000,
		st_f_init  = 6'b00_0001, // first forward step, no occ result yet
		st_f_run   = 6'b00_0010,
		st_f_break = 6'b00_0100,
		st_bck_ini = 6'b00_1000,
		st_bck_run = 6'b01_0000,
		st_bck_end = 6'b10_0000
	} status_e;

	typedef logic [`FMI_INTV_W-1:0]     intv_t;     // x0, x1, x2 or info
	typedef logic [`FMI_STEP_W-1:0]     step_t;     // position in the read
	typedef logic [`FMI_READ_NUM_W-1:0] read_num_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, a failing run exits nonzero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_fwd_extend \
	-f flist.f \
	--Mdir obj_dir

./obj_dir/Vtb_fwd_extend

// ==== verification/tb_fwd_extend.sv ====
`default_nettype none

`include "fmi_defs.svh"

module tb_fwd_extend;

	import smem_pkg::*;
	import mem_req_pkg::*;

	localparam int NUM_ITEMS   = 3000;
	localparam int MAIN_LIMIT  = 4 * NUM_ITEMS; // stall takes about a quarter
	localparam int DRAIN_LIMIT = 64;

	// every output of one item, collected when the item enters
	typedef struct packed {
		logic        we;
		ptr_t        curr_addr;
		curr_entry_t curr_data;
		read_num_t   curr_read_num;
		logic        ret_valid;
		step_t       ret;
		read_num_t   ret_read_num;
		status_e     query_status;
		read_num_t   query_read_num;
		step_t       query_pos;
		logic        dram_valid;
		dram_addr_t  addr_k, addr_l;
		status_e     status;
		step_t       step, min_intv, backward_x;
		ptr_t        ptr;
		read_num_t   read_num;
		intv_t       x0, x1, x2, info;
	} expect_t;

	logic      Clk_32UI;
	logic      reset_BWT_extend;
	logic      stall_i;
	intv_t     primary_i;
	status_e   status_i;
	step_t     step_i, min_intv_i, backward_x_i;
	ptr_t      ptr_i;
	read_num_t read_num_i;
	intv_t     ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i;
	intv_t     occ_x0_i, occ_x1_i, occ_x2_i;

	logic        curr_we_o, ret_valid_o, dram_valid_o;
	ptr_t        curr_addr_o, ptr_o;
	curr_entry_t curr_data_o;
	read_num_t   curr_read_num_o, ret_read_num_o, query_read_num_o, read_num_o;
	step_t       ret_o, next_query_pos_o, step_o, min_intv_o, backward_x_o;
	status_e     query_status_o, status_o;
	dram_addr_t  addr_k_o, addr_l_o;
	intv_t       ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o;

	logic [31:0] lfsr_q = 32'h15df_21ea;
	expect_t     exp_dec, exp_qry, exp_fin;
	expect_t     qry_q[$], fin_q[$];
	logic        qry_ok, fin_ok; // pipeline filled up to that output
	int          n_acc, n_we, n_ret, n_dram, n_small;

	fwd_extend_top fwd_extend_top_inst (.*);

	initial begin
		Clk_32UI = 1'b0;
		forever #4 Clk_32UI = ~Clk_32UI;
	end

	// ------------------------------
	// random source
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = {v[62:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic intv_t pick_x1();
		if (3'(take_bits(3)) == 3'd0)
			return primary_i + intv_t'(take_bits(2)); // k_tmp right at the primary row
		else
			return intv_t'(take_bits(40));
	endfunction

	// ------------------------------
	// reference model
	function automatic expect_t predict_item();
		expect_t e;
		status_e st;
		logic    brk, upd;
		intv_t   k_tmp, l_tmp, k_b, l_b;
		e     = '0;
		st    = status_i;
		upd   = 1'b0;
		brk   = (status_i == st_f_break)
			|| ((status_i == st_f_run) && (step_i >= step_t'(`FMI_READ_LEN)));
		e.ptr = ptr_i;
		if (brk) begin
			e.ret_valid = 1'b1;
			st          = st_bck_ini;
			if (step_i == step_t'(`FMI_READ_LEN)) begin
				e.we  = 1'b1;
				e.ptr = ptr_i + ptr_t'(1);
			end
		end else if (status_i == st_f_run) begin
			if (occ_x2_i != ik_x2_i) begin
				e.we  = 1'b1;
				e.ptr = ptr_i + ptr_t'(1);
				if (occ_x2_i < intv_t'(min_intv_i))
					st = st_f_break;
				else
					upd = 1'b1;
			end else begin
				upd = 1'b1;
			end
		end
		e.curr_addr     = ptr_i;
		e.curr_data     = {ik_info_i, ik_x2_i, ik_x1_i, ik_x0_i};
		e.curr_read_num = read_num_i;
		e.ret           = ik_info_i[`FMI_STEP_W-1:0];
		e.ret_read_num  = read_num_i;
		e.x0   = upd ? occ_x0_i : ik_x0_i;
		e.x1   = upd ? occ_x1_i : ik_x1_i;
		e.x2   = upd ? occ_x2_i : ik_x2_i;
		e.step = upd ? step_i + step_t'(1) : step_i;
		e.info = upd ? intv_t'(step_i) + intv_t'(1) : ik_info_i;
		e.query_status   = st;
		e.query_read_num = read_num_i;
		e.query_pos      = e.step;
		k_tmp = e.x1 - intv_t'(1);
		l_tmp = k_tmp + e.x2;
		k_b   = (k_tmp >= primary_i) ? k_tmp - intv_t'(1) : k_tmp;
		l_b   = (l_tmp >= primary_i) ? l_tmp - intv_t'(1) : l_tmp;
		if ((st == st_f_init) || (st == st_f_run)) begin
			e.dram_valid = 1'b1;
			e.addr_k     = {k_b[`FMI_LINE_HI:`FMI_LINE_LO], {`FMI_LINE_PAD{1'b0}}};
			e.addr_l     = {l_b[`FMI_LINE_HI:`FMI_LINE_LO], {`FMI_LINE_PAD{1'b0}}};
		end
		e.status     = (st == st_f_init) ? st_f_run : st;
		e.min_intv   = min_intv_i;
		e.backward_x = backward_x_i;
		e.read_num   = read_num_i;
		return e;
	endfunction

	// ------------------------------
	// checks
	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_error(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		$display("error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_status(input string name, input status_e got, input status_e exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_intv(input string name, input intv_t got, input intv_t exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_step(input string name, input step_t got, input step_t exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_ptr(input string name, input ptr_t got, input ptr_t exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_read_num(input string name, input read_num_t got,
		input read_num_t exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
		if (got !== exp)
			report_error(name, 256'(got), 256'(exp));
	endtask

	task automatic check_entry(input string name, input curr_entry_t got,
		input curr_entry_t exp);
		if (got !== exp)
			report_error(name, got, exp);
	endtask

	task automatic check_outputs();
		check_flag("curr_we_o", curr_we_o, exp_dec.we);
		check_ptr("curr_addr_o", curr_addr_o, exp_dec.curr_addr);
		check_entry("curr_data_o", curr_data_o, exp_dec.curr_data);
		check_read_num("curr_read_num_o", curr_read_num_o, exp_dec.curr_read_num);
		check_flag("ret_valid_o", ret_valid_o, exp_dec.ret_valid);
		if (exp_dec.ret_valid) begin
			check_step("ret_o", ret_o, exp_dec.ret);
			check_read_num("ret_read_num_o", ret_read_num_o, exp_dec.ret_read_num);
		end
		if (qry_ok) begin
			check_status("query_status_o", query_status_o, exp_qry.query_status);
			check_read_num("query_read_num_o", query_read_num_o, exp_qry.query_read_num);
			check_step("next_query_pos_o", next_query_pos_o, exp_qry.query_pos);
		end
		if (fin_ok) begin
			check_flag("dram_valid_o", dram_valid_o, exp_fin.dram_valid);
			check_addr("addr_k_o", addr_k_o, exp_fin.addr_k);
			check_addr("addr_l_o", addr_l_o, exp_fin.addr_l);
			check_status("status_o", status_o, exp_fin.status);
			check_step("step_o", step_o, exp_fin.step);
			check_step("min_intv_o", min_intv_o, exp_fin.min_intv);
			check_step("backward_x_o", backward_x_o, exp_fin.backward_x);
			check_ptr("ptr_o", ptr_o, exp_fin.ptr);
			check_read_num("read_num_o", read_num_o, exp_fin.read_num);
			check_intv("ik_x0_o", ik_x0_o, exp_fin.x0);
			check_intv("ik_x1_o", ik_x1_o, exp_fin.x1);
			check_intv("ik_x2_o", ik_x2_o, exp_fin.x2);
			check_intv("ik_info_o", ik_info_o, exp_fin.info);
		end
	endtask

	// ------------------------------
	// stimulus
	task automatic drive_random_item();
		step_t step, min_intv;
		intv_t x2;
		step     = (take_bits(1) == 64'd1) ? step_t'(95) + step_t'(take_bits(3))
			: step_t'(take_bits(7)); // half of the items near the read end
		min_intv = step_t'(take_bits(7));
		x2       = intv_t'(take_bits(20));
		case (3'(take_bits(3)))
			3'd4:    status_i <= st_f_break;
			3'd5:    status_i <= st_f_init;
			3'd6:    status_i <= (take_bits(1) == 64'd1) ? st_bck_run : st_bck_end;
			3'd7:    status_i <= (take_bits(1) == 64'd1) ? st_bck_ini : st_bubble;
			default: status_i <= st_f_run;
		endcase
		step_i       <= step;
		min_intv_i   <= min_intv;
		backward_x_i <= step_t'(take_bits(7));
		ptr_i        <= ptr_t'(take_bits(7));
		read_num_i   <= read_num_t'(take_bits(10));
		ik_x0_i      <= intv_t'(take_bits(40));
		ik_x1_i      <= pick_x1();
		ik_x2_i      <= x2;
		ik_info_i    <= intv_t'(take_bits(64));
		occ_x0_i     <= intv_t'(take_bits(40));
		occ_x1_i     <= pick_x1();
		case (2'(take_bits(2)))
			2'd0:    occ_x2_i <= x2; // interval unchanged
			2'd1:    occ_x2_i <= intv_t'(min_intv >> 1);
			2'd2:    occ_x2_i <= intv_t'(min_intv); // just not below
			default: occ_x2_i <= intv_t'(take_bits(20));
		endcase
	endtask

	task automatic record_accept();
		expect_t e;
		e       = predict_item();
		exp_dec = e;
		n_acc++;
		qry_q.push_back(e);
		fin_q.push_back(e);
		if (qry_q.size() > 2) begin
			exp_qry = qry_q.pop_front();
			qry_ok  = 1'b1;
		end
		if (fin_q.size() > 3) begin
			exp_fin = fin_q.pop_front();
			fin_ok  = 1'b1;
		end
		if (e.we)
			n_we++;
		if (e.ret_valid)
			n_ret++;
		if (e.dram_valid)
			n_dram++;
		if (e.status == st_f_break)
			n_small++;
	endtask

	task automatic run_cycle(input logic fresh);
		@(posedge Clk_32UI);
		if (!stall_i)
			record_accept();
		if (fresh)
			drive_random_item(); // a stalled pipeline must ignore these
		else
			status_i <= st_bubble;
		stall_i <= (2'(take_bits(2)) == 2'd0); // about a quarter of the cycles
		@(negedge Clk_32UI);
		check_outputs();
	endtask

	initial begin
		int cycles;
		int drain_from;
		reset_BWT_extend = 1'b0;
		stall_i          = 1'b0;
		primary_i        = intv_t'(take_bits(40));
		status_i         = st_bubble;
		step_i           = '0;
		min_intv_i       = '0;
		backward_x_i     = '0;
		ptr_i            = '0;
		read_num_i       = '0;
		ik_x0_i          = '0;
		ik_x1_i          = '0;
		ik_x2_i          = '0;
		ik_info_i        = '0;
		occ_x0_i         = '0;
		occ_x1_i         = '0;
		occ_x2_i         = '0;
		qry_ok           = 1'b0;
		fin_ok           = 1'b0;
		n_acc            = 0;
		n_we             = 0;
		n_ret            = 0;
		n_dram           = 0;
		n_small          = 0;

		for (int c = 0; c < 2; c++) begin
			@(posedge Clk_32UI);
			record_accept(); // bubbles enter while reset is low
			if (c == 1)
				reset_BWT_extend <= 1'b1;
			@(negedge Clk_32UI);
			check_flag("curr_we_o", curr_we_o, 1'b0);
			check_flag("ret_valid_o", ret_valid_o, 1'b0);
			check_flag("dram_valid_o", dram_valid_o, 1'b0);
			check_status("status_o", status_o, st_bubble);
			check_outputs();
		end

		cycles = 0;
		while (n_acc < NUM_ITEMS + 2) begin
			if (cycles == MAIN_LIMIT) begin
				$display("timeout: only %0d items accepted in %0d cycles", n_acc, cycles);
				abort_run();
			end
			run_cycle(1'b1);
			cycles++;
		end

		// bubbles push the last items out of the pipeline
		cycles     = 0;
		drain_from = n_acc;
		while (n_acc < drain_from + 4) begin
			if (cycles == DRAIN_LIMIT) begin
				$display("timeout: pipeline did not drain in %0d cycles", cycles);
				abort_run();
			end
			run_cycle(1'b0);
			cycles++;
		end

		$display("%0d items: %0d curr writes, %0d breaks, %0d dram requests, %0d min_intv stops",
			n_acc, n_we, n_ret, n_dram, n_small);
		if (n_we == 0 || n_ret == 0 || n_dram == 0 || n_small == 0) begin
			$display("stimulus never reached one of the step outcomes");
			abort_run();
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire
